// File: tb.f
+incdir+source
source/event_readout_pkg.sv
source/rdholdoff_timer.sv
source/event_sample_ram.sv
source/header_fifo.sv
source/event_output_mux.sv
source/event_readout_sm.sv
source/event_readout_top.sv
testbench/event_readout_tb.sv

// File: Bender.yml
package:
  name: event_readout

export_include_dirs:
  - source

sources:
  - include_dirs:
      - source
    files:
      - source/event_readout_pkg.sv
      - source/rdholdoff_timer.sv
      - source/event_sample_ram.sv
      - source/header_fifo.sv
      - source/event_output_mux.sv
      - source/event_readout_sm.sv
      - source/event_readout_top.sv
  - target: test
    include_dirs:
      - source
    files:
      - testbench/event_readout_tb.sv

// File: testbench/event_readout_tb.sv
`timescale 1ns/1ns
`include "event_readout_macros.svh"

module event_readout_tb
    import event_readout_pkg::*;
();

    localparam int NUM_EVENTS     = 4;
    localparam int WORDS_PER_BANK = 2 ** (`ER_UADDR_BITS + 2);
    // four header words, then every word of every bank of every channel
    localparam int N_WORDS        = 4 + `ER_CHANNELS * `ER_BANKS * WORDS_PER_BANK;
    localparam int TIMEOUT_CYCLES = 2000;

    logic       clk_i;
    logic       rdholdoff_reset;
    logic       clk_ce_i;
    holdoff_t   rdholdoff_i;
    sample_wr_t sample_wr_i;
    logic       hdr_push_i;
    sample_t    hdr_word_i;
    sample_t    ev_data_o;
    logic       ev_strobe_o;
    logic       ev_valid_o;
    logic       complete_o;

    // event table with four header words and the hold-off that follows each event
    sample_t  hdr_tab [NUM_EVENTS][4];
    holdoff_t hold_tab [NUM_EVENTS];

    // copy of what was written into the sample memories
    sample_t mirror [`ER_CHANNELS][`ER_BANKS][WORDS_PER_BANK];

    // header words waiting for the push driver
    sample_t push_q [$];

    logic [31:0] lcg_state;
    // enable ticks since the last completion pulse
    int          ce_since_complete;

    event_readout_top uut (
        .clk_i           (clk_i),
        .rdholdoff_reset (rdholdoff_reset),
        .clk_ce_i        (clk_ce_i),
        .rdholdoff_i     (rdholdoff_i),
        .sample_wr_i     (sample_wr_i),
        .hdr_push_i      (hdr_push_i),
        .hdr_word_i      (hdr_word_i),
        .ev_data_o       (ev_data_o),
        .ev_strobe_o     (ev_strobe_o),
        .ev_valid_o      (ev_valid_o),
        .complete_o      (complete_o)
    );

    initial begin
        clk_i = 1'b0;
        forever #10 clk_i = ~clk_i;
    end

    // enable on every second cycle
    always @(posedge clk_i) begin
        clk_ce_i <= ~clk_ce_i;
    end

    // one header word per cycle while words are queued
    always @(posedge clk_i) begin
        if (push_q.size() > 0) begin
            hdr_push_i <= 1'b1;
            hdr_word_i <= push_q.pop_front();
        end else begin
            hdr_push_i <= 1'b0;
        end
    end

    function automatic logic [31:0] lcg_next(input logic [31:0] s);
        return s * 32'd1103515245 + 32'd12345;
    endfunction

    task automatic check_value(input string name, input logic [31:0] got,
                               input logic [31:0] exp);
        if (got !== exp) begin
            $display("CHECK FAILED at %0t: %s got %0h expected %0h", $time, name, got, exp);
            $display("tests failed");
            $fatal(1, "stopped at first error");
        end
    endtask

    task automatic report_error(input string what);
        $display("ERROR at %0t: %s", $time, what);
        $display("tests failed");
        $fatal(1, "stopped at first error");
    endtask

    // advance to the falling edge and count enable ticks since complete_o
    task automatic next_cycle();
        @(negedge clk_i);
        if (complete_o) ce_since_complete = 0;
        else if (clk_ce_i) ce_since_complete++;
    endtask

    task automatic check_idle();
        check_value("ev_valid_o", ev_valid_o, 0);
        check_value("ev_strobe_o", ev_strobe_o, 0);
        check_value("complete_o", complete_o, 0);
    endtask

    task automatic set_row(input int row, input sample_t h0, input sample_t h1,
                           input sample_t h2, input sample_t h3, input holdoff_t hold);
        hdr_tab[row][0] = h0;
        hdr_tab[row][1] = h1;
        hdr_tab[row][2] = h2;
        hdr_tab[row][3] = h3;
        hold_tab[row]   = hold;
    endtask

    // random words into every channel, bank and address
    task automatic fill_memory();
        sample_wr_t w;
        for (int c = 0; c < `ER_CHANNELS; c++) begin
            for (int b = 0; b < `ER_BANKS; b++) begin
                for (int a = 0; a < WORDS_PER_BANK; a++) begin
                    lcg_state       = lcg_next(lcg_state);
                    mirror[c][b][a] = lcg_state[31:16];
                    w.wr   = 1'b1;
                    w.chan = chan_idx_t'(c);
                    w.bank = bank_idx_t'(b);
                    w.addr = ram_addr_t'(a);
                    w.data = mirror[c][b][a];
                    @(posedge clk_i);
                    sample_wr_i <= w;
                    next_cycle();
                    check_idle();
                end
            end
        end
        @(posedge clk_i);
        sample_wr_i <= '0;
    endtask

    task automatic read_event(input int row);
        sample_t exp_q [$];
        int      n;
        int      completes;
        int      waited;
        // headers in push order, then channel, bank and full address
        for (int i = 0; i < 4; i++) exp_q.push_back(hdr_tab[row][i]);
        for (int c = 0; c < `ER_CHANNELS; c++) begin
            for (int b = 0; b < `ER_BANKS; b++) begin
                for (int a = 0; a < WORDS_PER_BANK; a++) exp_q.push_back(mirror[c][b][a]);
            end
        end
        // previous hold-off is already loaded so the next value can go in
        @(posedge clk_i);
        rdholdoff_i <= hold_tab[row];
        waited = 0;
        do begin
            next_cycle();
            check_value("ev_strobe_o", ev_strobe_o, 0);
            waited++;
            if (waited > TIMEOUT_CYCLES) begin
                report_error($sformatf("timeout waiting for ev_valid_o of event %0d", row));
            end
        end while (!ev_valid_o);
        if (row > 0 && ce_since_complete < int'(hold_tab[row-1]) + 1) begin
            report_error($sformatf("event %0d started %0d enable ticks after complete_o",
                                   row, ce_since_complete));
        end
        n         = 0;
        completes = 0;
        waited    = 0;
        while (n < N_WORDS) begin
            next_cycle();
            check_value("ev_valid_o", ev_valid_o, 1);
            // completion comes with the tick that captures the final word
            if (complete_o) begin
                completes++;
                check_value("strobes before complete_o", n, N_WORDS - 1);
            end
            if (ev_strobe_o) begin
                check_value("ev_data_o", ev_data_o, exp_q[n]);
                n++;
            end
            waited++;
            if (waited > TIMEOUT_CYCLES) begin
                report_error($sformatf("timeout on word %0d of event %0d", n, row));
            end
        end
        waited = 0;
        while (ev_valid_o) begin
            next_cycle();
            if (complete_o) completes++;
            check_value("ev_strobe_o", ev_strobe_o, 0);
            waited++;
            if (waited > TIMEOUT_CYCLES) begin
                report_error($sformatf("timeout waiting for ev_valid_o to fall, event %0d", row));
            end
        end
        check_value("complete_o pulses", completes, 1);
    endtask

    initial begin
        rdholdoff_reset   = 1'b1;
        clk_ce_i          = 1'b0;
        rdholdoff_i       = '0;
        sample_wr_i       = '0;
        hdr_push_i        = 1'b0;
        hdr_word_i        = '0;
        lcg_state         = 32'd60283;
        ce_since_complete = 0;

        set_row(0, 16'hA0F1, 16'h0001, 16'h1234, 16'hBEEF, 24'd0);
        set_row(1, 16'hA0F2, 16'h0002, 16'h5A5A, 16'hC0DE, 24'd3);
        set_row(2, 16'hA0F3, 16'h0003, 16'h8001, 16'h7FFE, 24'd10);
        set_row(3, 16'hA0F4, 16'h0004, 16'hFFFF, 16'h0000, 24'd25);

        repeat (4) @(posedge clk_i);
        rdholdoff_reset <= 1'b0;

        // quiet outputs while nothing is queued
        repeat (10) begin
            next_cycle();
            check_idle();
        end
        fill_memory();
        repeat (10) begin
            next_cycle();
            check_idle();
        end

        // every event queued at once since the FIFO holds all four
        for (int r = 0; r < NUM_EVENTS; r++) begin
            for (int i = 0; i < 4; i++) push_q.push_back(hdr_tab[r][i]);
        end
        for (int r = 0; r < NUM_EVENTS; r++) begin
            read_event(r);
        end

        // nothing left to read after the last event
        repeat (80) begin
            next_cycle();
            check_idle();
        end

        $display("all tests passed");
        $finish;
    end

endmodule

// File: source/event_readout_top.sv
`timescale 1ns/1ns

module event_readout_top
    import event_readout_pkg::*;
(
    input  logic       clk_i,
    input  logic       rdholdoff_reset,
    input  logic       clk_ce_i,
    input  holdoff_t   rdholdoff_i,
    input  sample_wr_t sample_wr_i,
    input  logic       hdr_push_i,
    input  sample_t    hdr_word_i,
    output sample_t    ev_data_o,
    output logic       ev_strobe_o,
    output logic       ev_valid_o,
    output logic       complete_o
);

    logic     data_available;
    logic     header_rd;
    ram_rd_t  rd;
    out_sel_t sel;
    logic     valid;
    logic     holdoff_load;
    logic     holdoff_run;
    logic     holdoff_done;
    sample_t  hdr_word;
    sample_t  cas_data;

    event_readout_sm u_sm (
        .clk_i            (clk_i),
        .rdholdoff_reset  (rdholdoff_reset),
        .clk_ce_i         (clk_ce_i),
        .data_available_i (data_available),
        .header_rd_o      (header_rd),
        .rd_o             (rd),
        .sel_o            (sel),
        .valid_o          (valid),
        .complete_o       (complete_o),
        .holdoff_load_o   (holdoff_load),
        .holdoff_run_o    (holdoff_run),
        .holdoff_done_i   (holdoff_done)
    );

    rdholdoff_timer u_holdoff (
        .clk_i           (clk_i),
        .rdholdoff_reset (rdholdoff_reset),
        .clk_ce_i        (clk_ce_i),
        .load_i          (holdoff_load),
        .run_i           (holdoff_run),
        .rdholdoff_i     (rdholdoff_i),
        .done_o          (holdoff_done)
    );

    event_sample_ram u_ram (
        .clk_i           (clk_i),
        .rdholdoff_reset (rdholdoff_reset),
        .sample_wr_i     (sample_wr_i),
        .rd_i            (rd),
        .cas_data_o      (cas_data)
    );

    header_fifo u_hdr (
        .clk_i           (clk_i),
        .rdholdoff_reset (rdholdoff_reset),
        .push_i          (hdr_push_i),
        .word_i          (hdr_word_i),
        .rd_i            (header_rd),
        .word_o          (hdr_word),
        .available_o     (data_available)
    );

    event_output_mux u_out (
        .clk_i           (clk_i),
        .rdholdoff_reset (rdholdoff_reset),
        .clk_ce_i        (clk_ce_i),
        .sel_i           (sel),
        .valid_i         (valid),
        .hdr_word_i      (hdr_word),
        .cas_data_i      (cas_data),
        .ev_data_o       (ev_data_o),
        .ev_strobe_o     (ev_strobe_o)
    );

    // event-valid level comes straight from the controller
    assign ev_valid_o = valid;

endmodule

// File: source/event_readout_sm.sv
`timescale 1ns/1ns

module event_readout_sm
    import event_readout_pkg::*;
(
    input  logic     clk_i,
    input  logic     rdholdoff_reset,
    input  logic     clk_ce_i,
    input  logic     data_available_i,
    output logic     header_rd_o,
    output ram_rd_t  rd_o,
    output out_sel_t sel_o,
    output logic     valid_o,
    output logic     complete_o,
    output logic     holdoff_load_o,
    output logic     holdoff_run_o,
    input  logic     holdoff_done_i
);

    localparam int NBANK = $bits(bank_onehot_t);
    localparam int NCHAN = $bits(chan_onehot_t);

    readout_state_t state_q;
    uaddr_t         uaddr_q;
    bank_onehot_t   bank_q;
    chan_onehot_t   chan_q;
    logic           valid_q;
    logic           readout_complete_q;

    logic hdr_state;
    logic data_state;
    logic start_event;
    logic group_end;
    logic last_word;

    // header states carry bit 2 and PAUSE sits above them
    assign hdr_state  = state_q[2] && !state_q[3];
    assign data_state = (state_q[3:2] == 2'b00);

    // first enable tick in HEADER0 that sees a stored event
    assign start_event = clk_ce_i && (state_q == HEADER0) && data_available_i;

    // DATA2 issues lower address 3 and closes a group of four
    assign group_end = clk_ce_i && (state_q == DATA2);

    // final address of the final bank of the final channel
    assign last_word = (state_q == DATA2) && (&uaddr_q)
                       && bank_q[NBANK-1] && chan_q[NCHAN-1];

    // one state step per enable tick
    // HEADER0 waits one extra tick so valid is up before the first header word
    always_ff @(posedge clk_i) begin
        if (rdholdoff_reset) begin
            state_q <= HEADER0;
        end else if (clk_ce_i) begin
            case (state_q)
                HEADER0: if (valid_q) state_q <= HEADER1;
                HEADER1: state_q <= HEADER2;
                HEADER2: state_q <= HEADER3;
                HEADER3: state_q <= DATA0;
                DATA0:   state_q <= DATA1;
                DATA1:   state_q <= DATA2;
                DATA2:   state_q <= DATA3;
                DATA3: begin
                    if (readout_complete_q) state_q <= PAUSE;
                    else state_q <= DATA0;
                end
                PAUSE:   if (holdoff_done_i) state_q <= HEADER0;
                default: state_q <= HEADER0;
            endcase
        end
    end

    // valid drops on the first PAUSE tick once the last word has left
    always_ff @(posedge clk_i) begin
        if (rdholdoff_reset) begin
            valid_q <= 1'b0;
        end else if (start_event) begin
            valid_q <= 1'b1;
        end else if (clk_ce_i && (state_q == PAUSE)) begin
            valid_q <= 1'b0;
        end
    end

    // upper address steps every group of four
    // the bank rotates after its last address and the channel after its last bank
    // all three wrap back to the start after the final word
    always_ff @(posedge clk_i) begin
        if (rdholdoff_reset) begin
            uaddr_q <= '0;
            bank_q  <= '0;
            chan_q  <= '0;
        end else if (start_event) begin
            uaddr_q <= '0;
            bank_q  <= bank_onehot_t'(1);
            chan_q  <= chan_onehot_t'(1);
        end else if (group_end) begin
            uaddr_q <= uaddr_q + 1'b1;
            if (&uaddr_q) begin
                bank_q <= {bank_q[NBANK-2:0], bank_q[NBANK-1]};
            end
            if ((&uaddr_q) && bank_q[NBANK-1]) begin
                chan_q <= {chan_q[NCHAN-2:0], chan_q[NCHAN-1]};
            end
        end
    end

    // set once the last address is issued and held through DATA3
    always_ff @(posedge clk_i) begin
        if (rdholdoff_reset) begin
            readout_complete_q <= 1'b0;
        end else if (clk_ce_i) begin
            if (state_q == HEADER0) readout_complete_q <= 1'b0;
            else if (last_word) readout_complete_q <= 1'b1;
        end
    end

    // lower address comes straight from the state code
    assign rd_o.addr    = {uaddr_q, state_q[1:0]};
    assign rd_o.bank_en = bank_q;
    assign rd_o.chan_en = chan_q;
    // HEADER3 already reads the first data word one tick ahead of the output
    assign rd_o.casdomux_en = clk_ce_i && ((state_q == HEADER3) || data_state);

    assign sel_o.sel_header = hdr_state;
    assign sel_o.word_ce    = (state_q != PAUSE);

    // one header word popped per header tick
    assign header_rd_o = clk_ce_i && valid_q && hdr_state;
    assign valid_o     = valid_q;
    assign complete_o  = clk_ce_i && readout_complete_q && (state_q == DATA3);

    // hold-off is loaded in the final DATA3 and counts down in PAUSE
    assign holdoff_load_o = readout_complete_q && (state_q == DATA3);
    assign holdoff_run_o  = (state_q == PAUSE);

    // address enables stay one-hot for the whole event
    a_onehot_en: assert property (@(posedge clk_i) disable iff (rdholdoff_reset)
        valid_q |-> $onehot(bank_q) && $onehot(chan_q));

    // completion only fires once the address walk has wrapped to the first word
    a_complete_end: assert property (@(posedge clk_i) disable iff (rdholdoff_reset)
        complete_o |-> (uaddr_q == '0) && bank_q[0] && chan_q[0]);

endmodule

// File: source/event_output_mux.sv
`timescale 1ns/1ns

module event_output_mux
    import event_readout_pkg::*;
(
    input  logic     clk_i,
    input  logic     rdholdoff_reset,
    input  logic     clk_ce_i,
    input  out_sel_t sel_i,
    input  logic     valid_i,
    input  sample_t  hdr_word_i,
    input  sample_t  cas_data_i,
    output sample_t  ev_data_o,
    output logic     ev_strobe_o
);

    sample_t data_q;
    logic    strobe_q;
    logic    take;

    // one word per enable tick while the event is open
    assign take = clk_ce_i && valid_i && sel_i.word_ce;

    // header words come straight from the FIFO head,
    // sample words from the cascade register
    always_ff @(posedge clk_i) begin
        if (rdholdoff_reset) begin
            data_q <= '0;
        end else if (take) begin
            data_q <= sel_i.sel_header ? hdr_word_i : cas_data_i;
        end
    end

    // strobe lasts the single cycle after the capture
    always_ff @(posedge clk_i) begin
        if (rdholdoff_reset) begin
            strobe_q <= 1'b0;
        end else begin
            strobe_q <= take;
        end
    end

    assign ev_data_o   = data_q;
    assign ev_strobe_o = strobe_q;

endmodule

// File: source/header_fifo.sv
`timescale 1ns/1ns
`include "event_readout_macros.svh"

module header_fifo
    import event_readout_pkg::*;
(
    input  logic    clk_i,
    input  logic    rdholdoff_reset,
    input  logic    push_i,
    input  sample_t word_i,
    input  logic    rd_i,
    output sample_t word_o,
    output logic    available_o
);

    localparam int WORDS    = `ER_HDR_EVENTS * 4;
    localparam int PTR_BITS = $clog2(WORDS);
    localparam int CNT_BITS = $clog2(`ER_HDR_EVENTS + 1);

    sample_t mem [WORDS];
    // extra top bit tells full from empty
    logic [PTR_BITS:0]   wr_ptr_q;
    logic [PTR_BITS:0]   rd_ptr_q;
    logic [CNT_BITS-1:0] events_q;
    logic                empty;
    logic                full;
    logic                ev_pushed;
    logic                ev_popped;

    assign empty = (wr_ptr_q == rd_ptr_q);
    assign full  = (wr_ptr_q[PTR_BITS] != rd_ptr_q[PTR_BITS])
                   && (wr_ptr_q[PTR_BITS-1:0] == rd_ptr_q[PTR_BITS-1:0]);

    // fourth word of an event closes or frees it
    assign ev_pushed = push_i && (&wr_ptr_q[1:0]);
    assign ev_popped = rd_i && (&rd_ptr_q[1:0]);

    always_ff @(posedge clk_i) begin
        if (push_i) mem[wr_ptr_q[PTR_BITS-1:0]] <= word_i;
    end

    always_ff @(posedge clk_i) begin
        if (rdholdoff_reset) begin
            wr_ptr_q <= '0;
            rd_ptr_q <= '0;
            events_q <= '0;
        end else begin
            if (push_i) wr_ptr_q <= wr_ptr_q + 1'b1;
            if (rd_i) rd_ptr_q <= rd_ptr_q + 1'b1;
            if (ev_pushed && !ev_popped) events_q <= events_q + 1'b1;
            else if (ev_popped && !ev_pushed) events_q <= events_q - 1'b1;
        end
    end

    // head word, advanced by the controller one word at a time
    assign word_o      = mem[rd_ptr_q[PTR_BITS-1:0]];
    assign available_o = (events_q != '0);

    a_no_overflow: assert property (@(posedge clk_i) disable iff (rdholdoff_reset)
        push_i |-> !full);

    // reads only ever walk through a complete stored event
    a_no_underflow: assert property (@(posedge clk_i) disable iff (rdholdoff_reset)
        rd_i |-> !empty && available_o);

endmodule

// File: source/event_sample_ram.sv
`timescale 1ns/1ns
`include "event_readout_macros.svh"

module event_sample_ram
    import event_readout_pkg::*;
(
    input  logic       clk_i,
    input  logic       rdholdoff_reset,
    input  sample_wr_t sample_wr_i,
    input  ram_rd_t    rd_i,
    output sample_t    cas_data_o
);

    localparam int DEPTH = 2 ** $bits(ram_addr_t);

    // read data of each bank, zero unless that bank is the active one
    sample_t bank_out [`ER_CHANNELS][`ER_BANKS];
    sample_t cas_sel;
    sample_t cas_q;

    for (genvar c = 0; c < `ER_CHANNELS; c++) begin : g_chan
        for (genvar b = 0; b < `ER_BANKS; b++) begin : g_bank
            sample_t mem [DEPTH];
            sample_t rd_q;

            always_ff @(posedge clk_i) begin
                if (sample_wr_i.wr && (sample_wr_i.chan == c) && (sample_wr_i.bank == b)) begin
                    mem[sample_wr_i.addr] <= sample_wr_i.data;
                end
                // registered read, needs one idle cycle between enable ticks
                if (rd_i.chan_en[c] && rd_i.bank_en[b]) begin
                    rd_q <= mem[rd_i.addr];
                end
            end

            assign bank_out[c][b] = (rd_i.chan_en[c] && rd_i.bank_en[b]) ? rd_q : '0;
        end
    end

    // enables are one-hot, so an OR of the masked outputs is the bank mux
    always_comb begin
        cas_sel = '0;
        for (int c = 0; c < `ER_CHANNELS; c++) begin
            for (int b = 0; b < `ER_BANKS; b++) begin
                cas_sel = cas_sel | bank_out[c][b];
            end
        end
    end

    // cascade output register, one word per enable tick
    always_ff @(posedge clk_i) begin
        if (rdholdoff_reset) begin
            cas_q <= '0;
        end else if (rd_i.casdomux_en) begin
            cas_q <= cas_sel;
        end
    end

    assign cas_data_o = cas_q;

    a_wr_range: assert property (@(posedge clk_i) disable iff (rdholdoff_reset)
        sample_wr_i.wr |-> (sample_wr_i.chan < `ER_CHANNELS) && (sample_wr_i.bank < `ER_BANKS));

endmodule

// File: source/rdholdoff_timer.sv
`timescale 1ns/1ns

module rdholdoff_timer
    import event_readout_pkg::*;
(
    input  logic     clk_i,
    input  logic     rdholdoff_reset,
    input  logic     clk_ce_i,
    input  logic     load_i,
    input  logic     run_i,
    input  holdoff_t rdholdoff_i,
    output logic     done_o
);

    localparam int HB = $bits(holdoff_t);

    // one extra bit on top catches the borrow past zero
    logic [HB:0] count_q;

    // counter sits at zero whenever it is neither loaded nor running
    always_ff @(posedge clk_i) begin
        if (rdholdoff_reset || !(load_i || run_i)) begin
            count_q <= '0;
        end else if (clk_ce_i) begin
            if (load_i) begin
                count_q <= {1'b0, rdholdoff_i};
            end else if (run_i) begin
                count_q <= count_q - 1'b1;
            end
        end
    end

    // borrow set means the count has gone below zero
    assign done_o = count_q[HB];

endmodule

// File: source/event_readout_pkg.sv
`include "event_readout_macros.svh"

package event_readout_pkg;

    typedef logic [`ER_DATA_BITS-1:0]         sample_t;
    typedef logic [`ER_UADDR_BITS-1:0]        uaddr_t;
    // upper address followed by the two lower bits
    typedef logic [`ER_UADDR_BITS+1:0]        ram_addr_t;
    typedef logic [`ER_CHANNELS-1:0]          chan_onehot_t;
    typedef logic [`ER_BANKS-1:0]             bank_onehot_t;
    typedef logic [$clog2(`ER_CHANNELS)-1:0]  chan_idx_t;
    typedef logic [$clog2(`ER_BANKS)-1:0]     bank_idx_t;
    typedef logic [`ER_HOLDOFF_BITS-1:0]      holdoff_t;

    // low two bits are the lower address, bit 2 flags the header states
    typedef enum logic [3:0] {
        DATA3   = 4'd0,
        DATA0   = 4'd1,
        DATA1   = 4'd2,
        DATA2   = 4'd3,
        HEADER3 = 4'd4,
        HEADER0 = 4'd5,
        HEADER1 = 4'd6,
        HEADER2 = 4'd7,
        PAUSE   = 4'd8
    } readout_state_t;

    // capture side write into one channel and bank
    typedef struct packed {
        logic      wr;
        chan_idx_t chan;
        bank_idx_t bank;
        ram_addr_t addr;
        sample_t   data;
    } sample_wr_t;

    typedef struct packed {
        ram_addr_t    addr;
        bank_onehot_t bank_en;
        chan_onehot_t chan_en;
        logic         casdomux_en;
    } ram_rd_t;

    typedef struct packed {
        logic sel_header;
        logic word_ce;
    } out_sel_t;

endpackage

// File: source/event_readout_macros.svh
`ifndef EVENT_READOUT_MACROS_SVH
`define EVENT_READOUT_MACROS_SVH

// number of channels walked per event
`define ER_CHANNELS 2

// cascaded memory banks behind each channel
`define ER_BANKS 3

// upper address width, the two lower bits come from the FSM state
// 2 bits here gives 16 words per bank
`define ER_UADDR_BITS 2

// width of one sample word, header words use the same width
`define ER_DATA_BITS 16

// header FIFO depth counted in events of four words
`define ER_HDR_EVENTS 4

// hold-off load value width, counted in enable ticks
`define ER_HOLDOFF_BITS 24

`endif
